// File: basics_pkg.sv
`default_nettype none

package basics_pkg;

	// Command addresses carried in byte 0 of a master frame
	localparam logic [7:0] ADDR_QUERY     = 8'h56;
	localparam logic [7:0] ADDR_VERSION   = 8'h76;
	localparam logic [7:0] ADDR_QUERY_I2C = 8'h49;
	localparam logic [7:0] ADDR_SET_I2C   = 8'h69;

	// Parameter selectors for the I2C setting commands
	localparam logic [7:0] SEL_SPEED = 8'h63;
	localparam logic [7:0] SEL_ADDR  = 8'h61;

	// Response codes placed in the first body byte of an ACK/NAK frame
	localparam logic [7:0] CODE_ACK = 8'h06;
	localparam logic [7:0] CODE_NAK = 8'h15;

	localparam logic [7:0] VERSION_MAJOR = 8'h01;
	localparam logic [7:0] VERSION_MINOR = 8'h02;

	localparam logic [7:0]  I2C_SPEED_RESET = 8'd99;
	localparam logic [15:0] I2C_ADDR_RESET  = 16'hFFFF;

	// Output frame buffer, depth must equal 2**FIFO_PTR_W so pointers wrap on their own
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = 4;

	// Credits the consumer grants at reset
	localparam int OUT_CREDITS = 4;
	localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);

	typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
	// One bit wider than a pointer so a full buffer can be counted
	typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;
	typedef logic [CREDIT_W-1:0]   credit_t;

	typedef enum logic [2:0] {
		CMD_NAK,
		CMD_QUERY,
		CMD_VERSION,
		CMD_QUERY_I2C,
		CMD_SET_I2C
	} cmd_e;

	typedef enum logic [3:0] {
		EX_IDLE,
		EX_VER_HI,
		EX_VER_LO,
		EX_VER_CMP,
		EX_QUERY_SEL,
		EX_SET_SEL,
		EX_SET_VAL,
		EX_HOLD,
		EX_WAIT,
		EX_SEND
	} exec_state_e;

endpackage

`default_nettype wire

// File: cmd_decode.sv
`default_nettype none

module cmd_decode (
	input wire clk,
	input wire rst,

	input wire [7:0] ma_data,
	input wire ma_data_valid,
	input wire ma_frame_valid,
	input wire generate_nak,

	output logic cmd_valid,
	output basics_pkg::cmd_e cmd,
	output logic [7:0] eid,
	output logic [7:0] payload_data,
	output logic payload_valid
);

	// Position of the next byte in the frame; 3 means payload
	logic [1:0] pos;
	// Set when byte 0 named a command this block answers
	logic active;
	logic hit;
	logic strobe;
	basics_pkg::cmd_e cmd_next;

	assign strobe = ma_frame_valid && ma_data_valid;

	// An immediate NAK request wins over whatever address is on the bus
	always_comb begin
		hit = 1'b1;
		cmd_next = basics_pkg::CMD_NAK;
		if (!generate_nak) begin
			case (ma_data)
				basics_pkg::ADDR_QUERY:     cmd_next = basics_pkg::CMD_QUERY;
				basics_pkg::ADDR_VERSION:   cmd_next = basics_pkg::CMD_VERSION;
				basics_pkg::ADDR_QUERY_I2C: cmd_next = basics_pkg::CMD_QUERY_I2C;
				basics_pkg::ADDR_SET_I2C:   cmd_next = basics_pkg::CMD_SET_I2C;
				default:                    hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (strobe) begin
			payload_data <= ma_data;
			if (pos == 2'd0) begin
				cmd <= cmd_next;
			end
			if (pos == 2'd1) begin
				eid <= ma_data;
			end
		end

		if (rst) begin
			pos <= 2'd0;
			active <= 1'b0;
			cmd_valid <= 1'b0;
			payload_valid <= 1'b0;
		end else begin
			// The length byte itself is not used, it only marks the command as complete
			cmd_valid <= strobe && (pos == 2'd2) && active;
			payload_valid <= strobe && (pos == 2'd3) && active;

			if (!ma_frame_valid) begin
				pos <= 2'd0;
				active <= 1'b0;
			end else if (ma_data_valid) begin
				if (pos == 2'd0) begin
					active <= hit;
				end
				if (pos != 2'd3) begin
					pos <= pos + 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: cmd_execute.sv
`default_nettype none

module cmd_execute (
	input wire clk,
	input wire rst,

	input wire cmd_valid,
	input var basics_pkg::cmd_e cmd,
	input wire [7:0] eid,
	input wire [7:0] payload_data,
	input wire payload_valid,
	input wire framer_busy,

	output logic ack_req,
	output logic nak_req,
	output logic [7:0] resp_eid,
	output logic [7:0] frame_data,
	output logic frame_push,
	output logic frame_commit,

	output logic [7:0] i2c_speed,
	output logic [15:0] i2c_addr
);

	basics_pkg::exec_state_e state, next_state;

	logic [15:0] version_in;
	// Bytes of a data frame, sent low byte first
	logic [15:0] staging;
	// Bytes left to send or to receive
	logic [1:0] count;
	logic to_addr;

	logic ack_d, nak_d;
	logic stage_ver, stage_speed, stage_addr;
	logic shift_ver;
	logic sel_speed, sel_addr;
	logic write_val;
	logic push_d;

	always_comb begin
		next_state = state;
		ack_d = 1'b0;
		nak_d = 1'b0;
		stage_ver = 1'b0;
		stage_speed = 1'b0;
		stage_addr = 1'b0;
		shift_ver = 1'b0;
		sel_speed = 1'b0;
		sel_addr = 1'b0;
		write_val = 1'b0;
		push_d = 1'b0;

		case (state)
			basics_pkg::EX_IDLE: begin
				if (cmd_valid) begin
					case (cmd)
						basics_pkg::CMD_NAK: begin
							nak_d = 1'b1;
						end
						basics_pkg::CMD_QUERY: begin
							ack_d = 1'b1;
							stage_ver = 1'b1;
							next_state = basics_pkg::EX_HOLD;
						end
						basics_pkg::CMD_VERSION:   next_state = basics_pkg::EX_VER_HI;
						basics_pkg::CMD_QUERY_I2C: next_state = basics_pkg::EX_QUERY_SEL;
						basics_pkg::CMD_SET_I2C:   next_state = basics_pkg::EX_SET_SEL;
						default:                   next_state = basics_pkg::EX_IDLE;
					endcase
				end
			end

			// Version arrives major byte first
			basics_pkg::EX_VER_HI: begin
				if (payload_valid) begin
					shift_ver = 1'b1;
					next_state = basics_pkg::EX_VER_LO;
				end
			end

			basics_pkg::EX_VER_LO: begin
				if (payload_valid) begin
					shift_ver = 1'b1;
					next_state = basics_pkg::EX_VER_CMP;
				end
			end

			basics_pkg::EX_VER_CMP: begin
				if (version_in == {basics_pkg::VERSION_MAJOR, basics_pkg::VERSION_MINOR}) begin
					ack_d = 1'b1;
					next_state = basics_pkg::EX_IDLE;
				end else begin
					// The master gets our version so it can tell what it is talking to
					nak_d = 1'b1;
					stage_ver = 1'b1;
					next_state = basics_pkg::EX_HOLD;
				end
			end

			basics_pkg::EX_QUERY_SEL: begin
				if (payload_valid) begin
					if (payload_data == basics_pkg::SEL_SPEED) begin
						ack_d = 1'b1;
						stage_speed = 1'b1;
						next_state = basics_pkg::EX_HOLD;
					end else if (payload_data == basics_pkg::SEL_ADDR) begin
						ack_d = 1'b1;
						stage_addr = 1'b1;
						next_state = basics_pkg::EX_HOLD;
					end else begin
						nak_d = 1'b1;
						next_state = basics_pkg::EX_IDLE;
					end
				end
			end

			basics_pkg::EX_SET_SEL: begin
				if (payload_valid) begin
					if (payload_data == basics_pkg::SEL_SPEED) begin
						sel_speed = 1'b1;
						next_state = basics_pkg::EX_SET_VAL;
					end else if (payload_data == basics_pkg::SEL_ADDR) begin
						sel_addr = 1'b1;
						next_state = basics_pkg::EX_SET_VAL;
					end else begin
						nak_d = 1'b1;
						next_state = basics_pkg::EX_IDLE;
					end
				end
			end

			basics_pkg::EX_SET_VAL: begin
				if (payload_valid) begin
					write_val = 1'b1;
					if (count == 2'd1) begin
						ack_d = 1'b1;
						next_state = basics_pkg::EX_IDLE;
					end
				end
			end

			// The framer only raises busy the cycle after our request
			basics_pkg::EX_HOLD: next_state = basics_pkg::EX_WAIT;

			basics_pkg::EX_WAIT: begin
				if (!framer_busy) begin
					next_state = basics_pkg::EX_SEND;
				end
			end

			basics_pkg::EX_SEND: begin
				push_d = 1'b1;
				if (count == 2'd1) begin
					next_state = basics_pkg::EX_IDLE;
				end
			end

			default: next_state = basics_pkg::EX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == basics_pkg::EX_IDLE && cmd_valid) begin
			resp_eid <= eid;
		end
		if (shift_ver) begin
			version_in <= {version_in[7:0], payload_data};
		end

		if (stage_ver) begin
			staging <= {basics_pkg::VERSION_MINOR, basics_pkg::VERSION_MAJOR};
			count <= 2'd2;
		end
		if (stage_speed) begin
			staging <= {8'h00, i2c_speed};
			count <= 2'd1;
		end
		if (stage_addr) begin
			staging <= i2c_addr;
			count <= 2'd2;
		end
		if (sel_speed) begin
			to_addr <= 1'b0;
			count <= 2'd1;
		end
		if (sel_addr) begin
			to_addr <= 1'b1;
			count <= 2'd2;
		end

		// New address comes in high byte first
		if (write_val) begin
			if (to_addr) begin
				i2c_addr <= {i2c_addr[7:0], payload_data};
			end else begin
				i2c_speed <= payload_data;
			end
			count <= count - 2'd1;
		end

		if (push_d) begin
			frame_data <= staging[7:0];
			staging <= {8'h00, staging[15:8]};
			count <= count - 2'd1;
		end

		if (rst) begin
			state <= basics_pkg::EX_IDLE;
			count <= 2'd0;
			ack_req <= 1'b0;
			nak_req <= 1'b0;
			frame_push <= 1'b0;
			frame_commit <= 1'b0;
			i2c_speed <= basics_pkg::I2C_SPEED_RESET;
			i2c_addr <= basics_pkg::I2C_ADDR_RESET;
		end else begin
			state <= next_state;
			ack_req <= ack_d;
			nak_req <= nak_d;
			frame_push <= push_d;
			frame_commit <= push_d && (count == 2'd1);
		end
	end

endmodule

`default_nettype wire

// File: response_framer.sv
`default_nettype none

module response_framer (
	input wire clk,
	input wire rst,

	input wire ack_req,
	input wire nak_req,
	input wire [7:0] resp_eid,
	input wire [7:0] frame_data,
	input wire frame_push,
	input wire frame_commit,

	output logic framer_busy,
	output logic [7:0] wr_data,
	output logic wr_push,
	output logic wr_commit
);

	typedef enum logic [1:0] {
		FR_IDLE,
		FR_CODE,
		FR_EID
	} framer_state_e;

	framer_state_e state;
	logic [7:0] code_q;
	logic [7:0] eid_q;

	always_ff @(posedge clk) begin
		if (state == FR_IDLE && (ack_req || nak_req)) begin
			code_q <= ack_req ? basics_pkg::CODE_ACK : basics_pkg::CODE_NAK;
			eid_q <= resp_eid;
		end

		if (rst) begin
			state <= FR_IDLE;
		end else begin
			case (state)
				FR_IDLE: begin
					if (ack_req || nak_req) begin
						state <= FR_CODE;
					end
				end
				FR_CODE: state <= FR_EID;
				default: state <= FR_IDLE;
			endcase
		end
	end

	assign framer_busy = (state != FR_IDLE);

	// Execute frames only flow while no ACK/NAK is being written
	always_comb begin
		case (state)
			FR_CODE: begin
				wr_data = code_q;
				wr_push = 1'b1;
				wr_commit = 1'b0;
			end
			FR_EID: begin
				wr_data = eid_q;
				wr_push = 1'b1;
				wr_commit = 1'b1;
			end
			default: begin
				wr_data = frame_data;
				wr_push = frame_push;
				wr_commit = frame_commit;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: message_fifo.sv
`default_nettype none

module message_fifo (
	input wire clk,
	input wire rst,

	input wire [7:0] wr_data,
	input wire wr_push,
	input wire wr_commit,

	input wire out_credit,
	output logic [7:0] out_data,
	output logic out_valid,
	output logic out_last,
	output logic overflow
);

	logic [7:0] mem [basics_pkg::FIFO_DEPTH];

	basics_pkg::fifo_ptr_t wr_ptr;
	// End of the last committed frame, where an overflowing frame rolls back to
	basics_pkg::fifo_ptr_t commit_ptr;
	basics_pkg::fifo_ptr_t rd_ptr;
	// Slot reserved for the length byte of the open frame
	basics_pkg::fifo_ptr_t len_ptr;
	basics_pkg::fifo_ptr_t slot_ptr, data_ptr;

	// Committed bytes not yet sent
	basics_pkg::fifo_cnt_t used;
	// Bytes of the open frame, length slot included
	basics_pkg::fifo_cnt_t frame_fill;
	basics_pkg::fifo_cnt_t need;
	// Body bytes still to send, zero when the next byte is a length byte
	basics_pkg::fifo_cnt_t rem;
	basics_pkg::credit_t credits;
	logic [basics_pkg::FIFO_PTR_W+1:0] total;

	logic in_frame, frame_bad;
	logic drop, store, commit_ok, commit_bad, send;

	always_comb begin
		// The first byte of a frame also takes the length slot in front of it
		need = in_frame ? frame_fill + 1'b1 : basics_pkg::fifo_cnt_t'(2);
		total = used + need;
		drop = frame_bad || (total > basics_pkg::FIFO_DEPTH);
		slot_ptr = in_frame ? len_ptr : wr_ptr;
		data_ptr = in_frame ? wr_ptr : wr_ptr + 1'b1;
		store = wr_push && !drop;
		commit_ok = store && wr_commit;
		commit_bad = wr_push && wr_commit && drop;
		send = (used != '0) && (credits != '0);
	end

	always_ff @(posedge clk) begin
		if (store) begin
			mem[data_ptr] <= wr_data;
		end
		if (commit_ok) begin
			mem[slot_ptr] <= 8'(need - 1'b1);
		end
		if (store && !in_frame) begin
			len_ptr <= wr_ptr;
		end
	end

	// Write side
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			commit_ptr <= '0;
			frame_fill <= '0;
			in_frame <= 1'b0;
			frame_bad <= 1'b0;
			overflow <= 1'b0;
		end else begin
			if (wr_push) begin
				in_frame <= !wr_commit;
				frame_bad <= drop && !wr_commit;
				if (store) begin
					frame_fill <= need;
					wr_ptr <= data_ptr + 1'b1;
				end
			end
			if (commit_ok) begin
				commit_ptr <= data_ptr + 1'b1;
			end
			// Whole frame is thrown away, nothing of it ever becomes readable
			if (commit_bad) begin
				wr_ptr <= commit_ptr;
				overflow <= 1'b1;
			end
		end
	end

	// Read side, one byte per credit
	always_ff @(posedge clk) begin
		if (send) begin
			out_data <= mem[rd_ptr];
		end

		if (rst) begin
			rd_ptr <= '0;
			rem <= '0;
			used <= '0;
			credits <= basics_pkg::credit_t'(basics_pkg::OUT_CREDITS);
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end else begin
			out_valid <= send;
			out_last <= send && (rem == 1);
			credits <= credits - send + out_credit;
			used <= used + (commit_ok ? need : '0) - send;
			if (send) begin
				rd_ptr <= rd_ptr + 1'b1;
				if (rem == '0) begin
					rem <= basics_pkg::fifo_cnt_t'(mem[rd_ptr]);
				end else begin
					rem <= rem - 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: basics_int.sv
`default_nettype none

module basics_int (
	input wire clk,
	input wire rst,

	// Master frames, no back-pressure
	input wire [7:0] ma_data,
	input wire ma_data_valid,
	input wire ma_frame_valid,
	input wire generate_nak,

	// Credit-controlled response stream
	input wire out_credit,
	output logic [7:0] out_data,
	output logic out_valid,
	output logic out_last,
	output logic overflow,

	output logic [7:0] i2c_speed,
	output logic [15:0] i2c_addr
);

	logic cmd_valid;
	basics_pkg::cmd_e cmd;
	logic [7:0] eid;
	logic [7:0] payload_data;
	logic payload_valid;

	logic ack_req, nak_req;
	logic [7:0] resp_eid;
	logic [7:0] frame_data;
	logic frame_push, frame_commit;
	logic framer_busy;

	logic [7:0] wr_data;
	logic wr_push, wr_commit;

	cmd_decode u_decode (
		.clk(clk),
		.rst(rst),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.generate_nak(generate_nak),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.eid(eid),
		.payload_data(payload_data),
		.payload_valid(payload_valid)
	);

	cmd_execute u_execute (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.eid(eid),
		.payload_data(payload_data),
		.payload_valid(payload_valid),
		.framer_busy(framer_busy),
		.ack_req(ack_req),
		.nak_req(nak_req),
		.resp_eid(resp_eid),
		.frame_data(frame_data),
		.frame_push(frame_push),
		.frame_commit(frame_commit),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr)
	);

	response_framer u_framer (
		.clk(clk),
		.rst(rst),
		.ack_req(ack_req),
		.nak_req(nak_req),
		.resp_eid(resp_eid),
		.frame_data(frame_data),
		.frame_push(frame_push),
		.frame_commit(frame_commit),
		.framer_busy(framer_busy),
		.wr_data(wr_data),
		.wr_push(wr_push),
		.wr_commit(wr_commit)
	);

	message_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.wr_data(wr_data),
		.wr_push(wr_push),
		.wr_commit(wr_commit),
		.out_credit(out_credit),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_last(out_last),
		.overflow(overflow)
	);

endmodule

`default_nettype wire

// File: tb_basics_int.sv
`default_nettype none

module tb_basics_int;

	localparam int NUM_ENTRIES = 22;
	// Budget of clock cycles for one table entry before the run counts as hung
	localparam int CYCLES_PER_ENTRY = 200;

	logic clk;
	logic rst;
	logic [7:0] ma_data;
	logic ma_data_valid;
	logic ma_frame_valid;
	logic generate_nak;
	logic out_credit = 1'b0;
	logic [7:0] out_data;
	logic out_valid;
	logic out_last;
	logic overflow;
	logic [7:0] i2c_speed;
	logic [15:0] i2c_addr;

	// Frame and response bytes sit left aligned in the table with byte 0 in the top bits
	logic [47:0] t_frame [NUM_ENTRIES];
	int t_flen [NUM_ENTRIES];
	bit t_nak [NUM_ENTRIES];
	// Held entries keep credits back and do not wait for their response
	bit t_hold [NUM_ENTRIES];
	logic [47:0] t_resp [NUM_ENTRIES];
	int t_rlen [NUM_ENTRIES];
	logic [7:0] t_speed [NUM_ENTRIES];
	logic [15:0] t_addr [NUM_ENTRIES];
	bit t_ovf [NUM_ENTRIES];
	int n_added = 0;

	logic [7:0] exp_q [$];
	// Counts the body bytes left in the expected frame and is zero when a length byte is next
	int exp_rem = 0;
	// Bytes received that the consumer has not yet credited back
	int owed = 0;
	int wait_cnt = 0;
	bit hold_credits = 1'b0;
	logic [31:0] rnd_state = 32'ha4209ff8;
	int cycles = 0;

	basics_int dut (
		.clk(clk),
		.rst(rst),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.generate_nak(generate_nak),
		.out_credit(out_credit),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_last(out_last),
		.overflow(overflow),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [23:0] ack_bytes(input logic [7:0] id);
		return {8'h02, basics_pkg::CODE_ACK, id};
	endfunction

	function automatic logic [23:0] nak_bytes(input logic [7:0] id);
		return {8'h02, basics_pkg::CODE_NAK, id};
	endfunction

	function automatic logic [23:0] version_bytes();
		return {8'h02, basics_pkg::VERSION_MAJOR, basics_pkg::VERSION_MINOR};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic add_entry(input logic [47:0] frame, input int flen, input bit nak,
			input bit hold, input logic [47:0] resp, input int rlen,
			input logic [7:0] speed, input logic [15:0] addr, input bit ovf);
		t_frame[n_added] = frame;
		t_flen[n_added] = flen;
		t_nak[n_added] = nak;
		t_hold[n_added] = hold;
		t_resp[n_added] = resp;
		t_rlen[n_added] = rlen;
		t_speed[n_added] = speed;
		t_addr[n_added] = addr;
		t_ovf[n_added] = ovf;
		n_added++;
	endtask

	// Each byte is followed by one idle cycle and generate_nak goes only with byte 0
	task automatic send_frame(input int idx);
		int k;
		ma_frame_valid = 1'b1;
		for (k = 0; k < t_flen[idx]; k++) begin
			ma_data = t_frame[idx][47 - 8 * k -: 8];
			ma_data_valid = 1'b1;
			generate_nak = t_nak[idx] && (k == 0);
			@(negedge clk);
			ma_data_valid = 1'b0;
			generate_nak = 1'b0;
			@(negedge clk);
		end
		ma_frame_valid = 1'b0;
		@(negedge clk);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > NUM_ENTRIES * CYCLES_PER_ENTRY + 10) begin
			$display("Timeout: the run did not finish within %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// The consumer model checks each output byte and returns credits after a random delay
	always @(negedge clk) begin
		logic [7:0] exp_byte;
		bit exp_last;
		out_credit = 1'b0;
		if (out_valid === 1'b1 && exp_q.size() == 0) begin
			$display("Output byte %h at time %0t arrived with no response pending",
				out_data, $time);
			$display("SOME TESTS FAILED");
			$fatal(1, "Unexpected output byte");
		end else if (out_valid === 1'b1 && owed >= basics_pkg::OUT_CREDITS) begin
			$display("A byte was sent at time %0t while no credit was left", $time);
			$display("SOME TESTS FAILED");
			$fatal(1, "Credit limit broken");
		end else begin
			if (out_valid === 1'b1) begin
				exp_byte = exp_q.pop_front();
				if (exp_rem == 0) begin
					exp_rem = exp_byte;
					exp_last = 1'b0;
				end else begin
					exp_rem--;
					exp_last = (exp_rem == 0);
				end
				check("out_data", out_data, exp_byte);
				check("out_last", out_last, exp_last);
				owed++;
			end
			if (!hold_credits && owed != 0) begin
				if (wait_cnt == 0) begin
					out_credit = 1'b1;
					owed--;
					rnd_state = xorshift(rnd_state);
					wait_cnt = rnd_state[1:0];
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	initial begin
		int i;
		int k;
		rst = 1'b1;
		ma_data = 8'h00;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		generate_nak = 1'b0;

		// Basic commands
		add_entry(48'h561100_000000, 3, 0, 0, {ack_bytes(8'h11), version_bytes()}, 6,
			8'd99, 16'hFFFF, 0);
		add_entry(48'h761202_010200, 5, 0, 0, {ack_bytes(8'h12), 24'h0}, 3, 8'd99, 16'hFFFF, 0);
		add_entry(48'h761302_010300, 5, 0, 0, {nak_bytes(8'h13), version_bytes()}, 6,
			8'd99, 16'hFFFF, 0);
		add_entry(48'h691402_632A00, 5, 0, 0, {ack_bytes(8'h14), 24'h0}, 3, 8'h2A, 16'hFFFF, 0);
		add_entry(48'h691503_611234, 6, 0, 0, {ack_bytes(8'h15), 24'h0}, 3, 8'h2A, 16'h1234, 0);
		add_entry(48'h491601_630000, 4, 0, 0, {ack_bytes(8'h16), 24'h012A00}, 5,
			8'h2A, 16'h1234, 0);
		add_entry(48'h491701_610000, 4, 0, 0, {ack_bytes(8'h17), 24'h023412}, 6,
			8'h2A, 16'h1234, 0);
		// Forced NAKs plus unknown addresses and selectors
		add_entry(48'h561800_000000, 3, 1, 0, {nak_bytes(8'h18), 24'h0}, 3, 8'h2A, 16'h1234, 0);
		add_entry(48'h331900_000000, 3, 1, 0, {nak_bytes(8'h19), 24'h0}, 3, 8'h2A, 16'h1234, 0);
		add_entry(48'h331A00_000000, 3, 0, 0, 48'h0, 0, 8'h2A, 16'h1234, 0);
		add_entry(48'h491B01_770000, 4, 0, 0, {nak_bytes(8'h1B), 24'h0}, 3, 8'h2A, 16'h1234, 0);
		add_entry(48'h691C02_775500, 5, 0, 0, {nak_bytes(8'h1C), 24'h0}, 3, 8'h2A, 16'h1234, 0);
		// Credits are held back while a silent frame gives the DUT time to stall
		add_entry(48'h562100_000000, 3, 0, 1, {ack_bytes(8'h21), version_bytes()}, 6,
			8'h2A, 16'h1234, 0);
		add_entry(48'h332201_000000, 4, 0, 1, 48'h0, 0, 8'h2A, 16'h1234, 0);
		add_entry(48'h0, 0, 0, 0, 48'h0, 0, 8'h2A, 16'h1234, 0);
		// Four held queries overrun the buffer so the last one is dropped whole
		add_entry(48'h563100_000000, 3, 0, 1, {ack_bytes(8'h31), version_bytes()}, 6,
			8'h2A, 16'h1234, 0);
		add_entry(48'h563200_000000, 3, 0, 1, {ack_bytes(8'h32), version_bytes()}, 6,
			8'h2A, 16'h1234, 0);
		add_entry(48'h563300_000000, 3, 0, 1, {ack_bytes(8'h33), version_bytes()}, 6,
			8'h2A, 16'h1234, 0);
		add_entry(48'h563400_000000, 3, 0, 1, 48'h0, 0, 8'h2A, 16'h1234, 1);
		add_entry(48'h333501_000000, 4, 0, 1, 48'h0, 0, 8'h2A, 16'h1234, 1);
		add_entry(48'h0, 0, 0, 0, 48'h0, 0, 8'h2A, 16'h1234, 1);
		add_entry(48'h563600_000000, 3, 0, 0, {ack_bytes(8'h36), version_bytes()}, 6,
			8'h2A, 16'h1234, 1);

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check("out_valid", out_valid, 1'b0);
		check("out_last", out_last, 1'b0);
		check("overflow", overflow, 1'b0);
		check("i2c_speed", i2c_speed, 8'd99);
		check("i2c_addr", i2c_addr, 16'hFFFF);

		for (i = 0; i < NUM_ENTRIES; i++) begin
			hold_credits <= t_hold[i];
			for (k = 0; k < t_rlen[i]; k++) begin
				exp_q.push_back(t_resp[i][47 - 8 * k -: 8]);
			end
			if (t_flen[i] != 0) begin
				send_frame(i);
			end
			if (!t_hold[i]) begin
				// Every expected byte seen and every credit handed back
				while (exp_q.size() != 0 || owed != 0) begin
					@(posedge clk);
				end
				@(negedge clk);
				check("i2c_speed", i2c_speed, t_speed[i]);
				check("i2c_addr", i2c_addr, t_addr[i]);
				check("overflow", overflow, t_ovf[i]);
			end
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
basics_pkg.sv
cmd_decode.sv
cmd_execute.sv
response_framer.sv
message_fifo.sv
basics_int.sv
tb_basics_int.sv

// File: Bender.yml
package:
  name: basics_int

sources:
  - files:
      - basics_pkg.sv
      - cmd_decode.sv
      - cmd_execute.sv
      - response_framer.sv
      - message_fifo.sv
      - basics_int.sv
  - target: simulation
    files:
      - tb_basics_int.sv
